//--- source/snd_dac_macros.svh
/* Sound DAC build constants */

`ifndef SND_DAC_MACROS_SVH
`define SND_DAC_MACROS_SVH

// Clock enable period in clk_dac cycles, also the ring length
`define SND_CEN_PERIOD 4

// Width of the unsigned word fed to each modulator
`define SND_DAC_W 20

// Signed integrator width, with headroom above the DAC word
`define SND_INT_W 24

// 1 for a stereo build, 0 folds the left channel onto both pins
`define SND_STEREO 1

`endif

//--- source/snd_dac_pkg.sv
/* Sound DAC shared types */

`include "snd_dac_macros.svh"

package snd_dac_pkg;

    // One PCM sample as the game core produces it.
    // Signed or offset binary, depending on the core
    typedef logic [15:0] pcm_sample_t;

    // Both channels of one PCM sample
    typedef struct packed {
        pcm_sample_t left;
        pcm_sample_t right;
    } stereo_pcm_t;

    // Unsigned modulator input word
    typedef logic [`SND_DAC_W-1:0] dac_word_t;

    // Held words for both modulators
    typedef struct packed {
        dac_word_t left;
        dac_word_t right;
    } stereo_dac_t;

    // Pulse-density pins, one bit per channel
    typedef struct packed {
        logic left;
        logic right;
    } pdm_bits_t;

endpackage

//--- source/dac_cen_gen.sv
/* DAC clock enable ring */

`timescale 1ns/1ns

`include "snd_dac_macros.svh"

module dac_cen_gen (
    input  logic clk_dac,
    input  logic rst,
    output logic cen_o
);

    localparam int RING_LEN = `SND_CEN_PERIOD;

    // Token starts two steps before the tap at bit 0
    localparam int START_POS = RING_LEN - 2;

    localparam logic [RING_LEN-1:0] RING_INIT = RING_LEN'(1) << START_POS;

    logic [RING_LEN-1:0] ring_q;

    // Rotate left by one position per cycle
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            ring_q <= RING_INIT;
        end else begin
            ring_q <= {ring_q[RING_LEN-2:0], ring_q[RING_LEN-1]};
        end
    end

    // Enable tap
    assign cen_o = ring_q[0];

endmodule

//--- source/snd_pcm_format.sv
/* PCM to DAC word formatter */

`timescale 1ns/1ns

`include "snd_dac_macros.svh"

module snd_pcm_format #(
    parameter int STEREO = `SND_STEREO
) (
    input  logic                      clk_dac,
    input  logic                      rst,
    input  logic                      cen_i,
    input  snd_dac_pkg::stereo_pcm_t  snd_i,
    input  logic                      signed_i,
    output snd_dac_pkg::stereo_dac_t  word_o
);

    import snd_dac_pkg::*;

    // Padding around the sample inside the DAC word
    localparam int PAD_LO = 3;
    localparam int PAD_HI = `SND_DAC_W - $bits(pcm_sample_t) - PAD_LO;

    pcm_sample_t right_src;
    stereo_dac_t word_d;
    stereo_dac_t word_q;

    // Offset binary conversion plus padding.
    // Flipping the sign bit moves the signed range up by half scale
    function automatic dac_word_t pad_sample(
        input pcm_sample_t sample,
        input logic        to_offset
    );
        pcm_sample_t offset_s;
        begin
            offset_s = sample;
            offset_s[$bits(pcm_sample_t)-1] = sample[$bits(pcm_sample_t)-1] ^ to_offset;
            pad_sample = {{PAD_HI{1'b0}}, offset_s, {PAD_LO{1'b0}}};
        end
    endfunction

    // Mono build takes the right pin from the left sample
    assign right_src = (STEREO != 0) ? snd_i.right : snd_i.left;

    always_comb begin
        word_d.left  = pad_sample(snd_i.left, signed_i);
        word_d.right = pad_sample(right_src, signed_i);
    end

    // Words only move on the enable, so the modulators see a stable input
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            word_q <= '0;
        end else if (cen_i) begin
            word_q <= word_d;
        end
    end

    assign word_o = word_q;

endmodule

//--- source/sigma_delta_dac.sv
/* Second-order sigma-delta DAC */

`timescale 1ns/1ns

`include "snd_dac_macros.svh"

module sigma_delta_dac (
    input  logic                    clk_dac,
    input  logic                    rst,
    input  logic                    cen_i,
    input  snd_dac_pkg::dac_word_t  word_i,
    output logic                    pdm_o
);

    localparam int DAC_W = `SND_DAC_W;
    localparam int INT_W = `SND_INT_W;

    // Full scale step subtracted when the output bit is high
    localparam logic signed [INT_W-1:0] FB_FULL = INT_W'(1) << DAC_W;

    logic signed [INT_W-1:0] x_ext;
    logic signed [INT_W-1:0] fb;
    logic signed [INT_W-1:0] int1_q;
    logic signed [INT_W-1:0] int2_q;
    logic signed [INT_W-1:0] int1_d;
    logic signed [INT_W-1:0] int2_d;
    logic                    bit_d;
    logic                    bit_q;

    // Word is unsigned, so zero extend into the signed range
    assign x_ext = $signed({{(INT_W-DAC_W){1'b0}}, word_i});

    // Feedback selected by the registered output bit
    assign fb = bit_q ? FB_FULL : '0;

    always_comb begin
        // First stage integrates the error against the input
        int1_d = int1_q + x_ext - fb;
        // Second stage integrates the first stage output
        int2_d = int2_q + int1_d - fb;
        // Quantizer, high when the second integrator is not negative
        bit_d  = ~int2_d[INT_W-1];
    end

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            int1_q <= '0;
            int2_q <= '0;
            bit_q  <= 1'b0;
        end else if (cen_i) begin
            int1_q <= int1_d;
            int2_q <= int2_d;
            bit_q  <= bit_d;
        end
    end

    // Pin comes straight from a flop, no glitches
    assign pdm_o = bit_q;

endmodule

//--- source/snd_dac_top.sv
/* Sound DAC output path */

`timescale 1ns/1ns

`include "snd_dac_macros.svh"

module snd_dac_top (
    input  logic                      clk_dac,
    input  logic                      rst,
    input  snd_dac_pkg::stereo_pcm_t  snd_i,
    input  logic                      signed_i,
    output wire snd_dac_pkg::pdm_bits_t pdm_o
);

    import snd_dac_pkg::*;

    logic        cen;
    stereo_dac_t word;

    // One enable every four clk_dac cycles
    dac_cen_gen u_cen (
        .clk_dac ( clk_dac ),
        .rst     ( rst     ),
        .cen_o   ( cen     )
    );

    // Sign conversion, padding and mono fold
    snd_pcm_format #(
        .STEREO ( `SND_STEREO )
    ) u_format (
        .clk_dac  ( clk_dac  ),
        .rst      ( rst      ),
        .cen_i    ( cen      ),
        .snd_i    ( snd_i    ),
        .signed_i ( signed_i ),
        .word_o   ( word     )
    );

    sigma_delta_dac u_dac_left (
        .clk_dac ( clk_dac    ),
        .rst     ( rst        ),
        .cen_i   ( cen        ),
        .word_i  ( word.left  ),
        .pdm_o   ( pdm_o.left )
    );

    // Mono builds feed this one the left word
    sigma_delta_dac u_dac_right (
        .clk_dac ( clk_dac     ),
        .rst     ( rst         ),
        .cen_i   ( cen         ),
        .word_i  ( word.right  ),
        .pdm_o   ( pdm_o.right )
    );

endmodule

//--- tests/snd_dac_assertions.sv
/* Sound DAC assertions */

`timescale 1ns/1ns

`include "snd_dac_macros.svh"

module snd_dac_assertions (
    input logic                    clk_dac,
    input logic                    rst,
    input logic                    cen_i,
    input snd_dac_pkg::pdm_bits_t  pdm_i
);

    import snd_dac_pkg::*;

    // Failures seen so far, read by the testbench
    int unsigned fail_cnt = 0;

    // Exactly one enable in every period
    cen_period_a: assert property (
        @(posedge clk_dac) disable iff (rst)
        cen_i |=> !cen_i [*(`SND_CEN_PERIOD - 1)] ##1 cen_i
    ) else begin
        $error("clock enable is not one-hot over its period");
        fail_cnt++;
    end

    // Pins move only right after an enable edge
    pdm_after_cen_a: assert property (
        @(posedge clk_dac) disable iff (rst)
        !$stable(pdm_i) |-> $past(cen_i)
    ) else begin
        $error("pdm_o changed outside the cycle after an enable");
        fail_cnt++;
    end

    // Quiet pins in reset
    pdm_reset_a: assert property (
        @(posedge clk_dac)
        rst |-> (pdm_i == '0)
    ) else begin
        $error("pdm_o is not zero during reset");
        fail_cnt++;
    end

endmodule

bind snd_dac_top snd_dac_assertions u_assert (
    .clk_dac ( clk_dac ),
    .rst     ( rst     ),
    .cen_i   ( cen     ),
    .pdm_i   ( pdm_o   )
);

//--- tests/tb_snd_dac.sv
/* Sound DAC testbench */

`timescale 1ns/1ns

`include "snd_dac_macros.svh"

module tb_snd_dac;

    import snd_dac_pkg::*;

    localparam int     CLK_HALF     = 50;
    localparam int     INT_W        = `SND_INT_W;
    localparam int     DAC_W        = `SND_DAC_W;
    localparam int     RING_LEN     = `SND_CEN_PERIOD;
    localparam int     DENS_ENABLES = 4096;
    localparam longint WATCHDOG_NS  = 64'd100000 * 2 * CLK_HALF;

    // Feedback step of 2^20
    localparam logic signed [INT_W-1:0] FB_STEP = INT_W'(1) << DAC_W;

    logic        clk_dac;
    logic        rst;
    stereo_pcm_t snd;
    logic        sgn;
    pdm_bits_t   pdm;

    // Reference model state
    logic [RING_LEN-1:0]     m_ring;
    stereo_dac_t             m_word;
    logic signed [INT_W-1:0] m_int1 [2];
    logic signed [INT_W-1:0] m_int2 [2];
    logic                    m_bit [2];
    logic                    m_cen_seen;

    logic vary_sgn;
    logic hold_snd;
    int   toggle_wait;
    int   split_cnt;

    snd_dac_top dut0 (
        .clk_dac  ( clk_dac ),
        .rst      ( rst     ),
        .snd_i    ( snd     ),
        .signed_i ( sgn     ),
        .pdm_o    ( pdm     )
    );

    initial begin
        clk_dac = 1'b0;
        forever #CLK_HALF clk_dac = ~clk_dac;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_pdm(input string name, input pdm_bits_t got, input pdm_bits_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED time=%0t signal=%s got=%b expected=%b",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input dac_word_t got, input dac_word_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED time=%0t signal=%s got=%h expected=%h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp, input int tol);
        if (got > exp + tol || got < exp - tol) begin
            stop_on_error($sformatf("FAILED time=%0t signal=%s got=%0d expected=%0d (tol %0d)",
                                    $time, name, got, exp, tol));
        end
    endtask

    // Bound checker counts its own failures
    task automatic check_assertions();
        if (dut0.u_assert.fail_cnt != 0) begin
            stop_on_error("a concurrent assertion in snd_dac_assertions failed");
        end
    endtask

    // Sample goes to bits 18..3
    // Top sample bit flipped for two's complement input
    function automatic dac_word_t fmt_word(input pcm_sample_t s, input logic is_signed);
        dac_word_t w;
        begin
            w = '0;
            w[DAC_W-2 -: 16] = s;
            if (is_signed) begin
                w[DAC_W-2] = ~w[DAC_W-2];
            end
            return w;
        end
    endfunction

    task automatic model_reset();
        begin
            m_ring     = RING_LEN'(1) << (RING_LEN - 2);
            m_word     = '0;
            m_cen_seen = 1'b0;
            for (int ch = 0; ch < 2; ch++) begin
                m_int1[ch] = '0;
                m_int2[ch] = '0;
                m_bit[ch]  = 1'b0;
            end
        end
    endtask

    task automatic model_channel(input int ch, input dac_word_t x);
        logic signed [INT_W-1:0] fb;
        begin
            fb = m_bit[ch] ? FB_STEP : '0;
            m_int1[ch] = m_int1[ch] + INT_W'(x) - fb;
            m_int2[ch] = m_int2[ch] + m_int1[ch] - fb;
            m_bit[ch]  = (m_int2[ch] >= 0);
        end
    endtask

    // One rising edge of the model
    // Inputs are the ones driven on the last falling edge
    task automatic model_step();
        stereo_dac_t cap;
        begin
            m_cen_seen = 1'b0;
            if (rst) begin
                model_reset();
            end else begin
                if (m_ring[0]) begin
                    model_channel(0, m_word.left);
                    model_channel(1, m_word.right);
                    cap.left  = fmt_word(snd.left, sgn);
                    cap.right = (`SND_STEREO != 0) ? fmt_word(snd.right, sgn) : cap.left;
                    m_word     = cap;
                    m_cen_seen = 1'b1;
                end
                m_ring = {m_ring[RING_LEN-2:0], m_ring[RING_LEN-1]};
            end
        end
    endtask

    task automatic drive_inputs();
        if (!hold_snd) begin
            snd = stereo_pcm_t'($urandom);
            if (vary_sgn) begin
                if (toggle_wait == 0) begin
                    sgn         = ~sgn;
                    toggle_wait = 200 + int'($urandom % 300);
                end else begin
                    toggle_wait--;
                end
            end
        end
    endtask

    task automatic run_cycle();
        pdm_bits_t exp_pdm;
        pdm_bits_t mono_pdm;
        begin
            @(posedge clk_dac);
            model_step();
            @(negedge clk_dac);
            exp_pdm.left  = m_bit[0];
            exp_pdm.right = m_bit[1];
            check_pdm("pdm_o", pdm, exp_pdm);
            check_word("word.left", dut0.word.left, m_word.left);
            check_word("word.right", dut0.word.right, m_word.right);
            if (`SND_STEREO == 0) begin
                mono_pdm       = pdm;
                mono_pdm.right = pdm.left;
                check_pdm("pdm_o.right", pdm, mono_pdm);
            end
            check_assertions();
            if (m_bit[0] != m_bit[1]) begin
                split_cnt++;
            end
            drive_inputs();
        end
    endtask

    task automatic wait_enable();
        int n;
        begin
            n = 0;
            run_cycle();
            while (!m_cen_seen) begin
                n++;
                if (n > 2 * RING_LEN) begin
                    stop_on_error("timeout while waiting for the DAC clock enable");
                end
                run_cycle();
            end
        end
    endtask

    task automatic apply_reset();
        begin
            rst = 1'b1;
            model_reset();
            repeat (10) begin
                @(posedge clk_dac);
                model_step();
                @(negedge clk_dac);
                check_pdm("pdm_o", pdm, '0);
                check_assertions();
            end
            rst = 1'b0;
        end
    endtask

    // Ones counted over a fixed number of enables with a constant sample
    task automatic density_test();
        dac_word_t x [2];
        int        m_ones [2];
        int        d_ones [2];
        longint    ideal;
        begin
            vary_sgn   = 1'b0;
            sgn        = 1'b0;
            snd.left   = 16'h6000 + 16'($urandom % 32'h2000);
            snd.right  = 16'h6000 + 16'($urandom % 32'h2000);
            hold_snd   = 1'b1;
            apply_reset();
            wait_enable();
            x[0] = m_word.left;
            x[1] = m_word.right;
            m_ones = '{0, 0};
            d_ones = '{0, 0};
            repeat (DENS_ENABLES) begin
                wait_enable();
                m_ones[0] += int'(m_bit[0]);
                m_ones[1] += int'(m_bit[1]);
                d_ones[0] += int'(pdm.left);
                d_ones[1] += int'(pdm.right);
            end
            for (int ch = 0; ch < 2; ch++) begin
                check_count($sformatf("ones_count[%0d]", ch), d_ones[ch], m_ones[ch], 0);
                ideal = (longint'(x[ch]) * DENS_ENABLES + (64'd1 << (DAC_W - 1))) >> DAC_W;
                check_count($sformatf("density[%0d]", ch), m_ones[ch], int'(ideal), 2);
            end
            hold_snd = 1'b0;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_on_error("timeout, the simulation did not finish in time");
    end

    initial begin
        void'($urandom(32'he4ad708e));
        rst         = 1'b1;
        snd         = '0;
        sgn         = 1'b0;
        vary_sgn    = 1'b0;
        hold_snd    = 1'b0;
        toggle_wait = 0;
        split_cnt   = 0;

        apply_reset();
        wait_enable();

        // Unsigned samples only
        repeat (20000) run_cycle();

        // Sign mode flips every few hundred cycles
        vary_sgn = 1'b1;
        repeat (20000) run_cycle();

        if (`SND_STEREO != 0 && split_cnt == 0) begin
            stop_on_error("left and right streams never differed in the stereo build");
        end

        density_test();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- tb.f
+incdir+source
source/snd_dac_pkg.sv
source/dac_cen_gen.sv
source/snd_pcm_format.sv
source/sigma_delta_dac.sv
source/snd_dac_top.sv
tests/snd_dac_assertions.sv
tests/tb_snd_dac.sv

//--- Bender.yml
package:
  name: snd_dac

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/snd_dac_pkg.sv
      - source/dac_cen_gen.sv
      - source/snd_pcm_format.sv
      - source/sigma_delta_dac.sv
      - source/snd_dac_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - tests/snd_dac_assertions.sv
      - tests/tb_snd_dac.sv
